//--- dv/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                  // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(negedge clk);              // covers three rising edges
        reset = 1'b0;
    end

endmodule

//--- dv/tb_tlb.sv
module tb_tlb;
    timeunit 1ns;
    timeprecision 1ps;
    import tlb_pkg::*;

    localparam string golden_path = "dv/tlb_golden.txt";

    logic       clk;
    logic       reset;
    vppn_t      s_vppn;
    logic       s_va_bit12;
    asid_t      s_asid;
    logic       s_found;
    index_t     s_index;
    ppn_t       s_ppn;
    ps_t        s_ps;
    plv_t       s_plv;
    mat_t       s_mat;
    logic       s_d, s_v;
    logic       invtlb_valid;
    invtlb_op_e invtlb_op;
    logic       we;
    index_t     w_index;
    logic       w_e, w_g;
    vppn_t      w_vppn;
    ps_t        w_ps;
    asid_t      w_asid;
    ppn_t       w_ppn0, w_ppn1;
    plv_t       w_plv0, w_plv1;
    mat_t       w_mat0, w_mat1;
    logic       w_d0, w_d1, w_v0, w_v1;
    index_t     r_index;
    logic       r_e, r_g;
    vppn_t      r_vppn;
    ps_t        r_ps;
    asid_t      r_asid;
    ppn_t       r_ppn0, r_ppn1;
    plv_t       r_plv0, r_plv1;
    mat_t       r_mat0, r_mat1;
    logic       r_d0, r_d1, r_v0, r_v1;

    // expected values as read from the golden file
    logic       exp_found, exp_e, exp_g, full_check;
    index_t     exp_index;
    vppn_t      exp_vppn;
    ps_t        exp_ps;
    asid_t      exp_asid;
    ppn_t       exp_ppn [2];
    plv_t       exp_plv [2];
    mat_t       exp_mat [2];
    logic       exp_d [2];
    logic       exp_v [2];
    logic [4:0] op_code;

    int fd;
    int n_cmds;
    int cycle_limit = 0;
    int cycles = 0;
    int checks = 0;
    int mismatches = 0;
    int file_errors = 0;

    tb_clock_gen u_clock_gen (.clk(clk), .reset(reset));

    tlb_top uut (.*);

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the golden commands did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            mismatches++;
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic check_search(input logic found, input index_t index, input ppn_t ppn,
                                input ps_t ps, input plv_t plv, input mat_t mat,
                                input logic d, input logic v);
        compare_field("s_found", 32'(s_found), 32'(found));
        compare_field("s_index", 32'(s_index), 32'(index));
        compare_field("s_ppn", 32'(s_ppn), 32'(ppn));
        compare_field("s_ps", 32'(s_ps), 32'(ps));
        compare_field("s_plv", 32'(s_plv), 32'(plv));
        compare_field("s_mat", 32'(s_mat), 32'(mat));
        compare_field("s_d", 32'(s_d), 32'(d));
        compare_field("s_v", 32'(s_v), 32'(v));
    endtask

    task automatic check_read(input logic full, input logic e, input vppn_t vppn, input ps_t ps,
                              input asid_t asid, input logic g,
                              input ppn_t ppn0, input plv_t plv0, input mat_t mat0,
                              input logic d0, input logic v0,
                              input ppn_t ppn1, input plv_t plv1, input mat_t mat1,
                              input logic d1, input logic v1);
        compare_field("r_e", 32'(r_e), 32'(e));
        if (full) begin                         // payload is unknown until written
            compare_field("r_vppn", 32'(r_vppn), 32'(vppn));
            compare_field("r_ps", 32'(r_ps), 32'(ps));
            compare_field("r_asid", 32'(r_asid), 32'(asid));
            compare_field("r_g", 32'(r_g), 32'(g));
            compare_field("r_ppn0", 32'(r_ppn0), 32'(ppn0));
            compare_field("r_plv0", 32'(r_plv0), 32'(plv0));
            compare_field("r_mat0", 32'(r_mat0), 32'(mat0));
            compare_field("r_d0", 32'(r_d0), 32'(d0));
            compare_field("r_v0", 32'(r_v0), 32'(v0));
            compare_field("r_ppn1", 32'(r_ppn1), 32'(ppn1));
            compare_field("r_plv1", 32'(r_plv1), 32'(plv1));
            compare_field("r_mat1", 32'(r_mat1), 32'(mat1));
            compare_field("r_d1", 32'(r_d1), 32'(d1));
            compare_field("r_v1", 32'(r_v1), 32'(v1));
        end
    endtask

    task automatic report_bad_line(input int num, input logic [7:0] cmd);
        file_errors++;
        $display("golden file command %0d (%c) is malformed or has too few fields", num, cmd);
    endtask

    // counts command lines and skips lines that start with #
    function automatic int count_commands();
        logic [7:0]    cmd;
        logic [1023:0] rest;
        int            cfd;
        int            n;
        n = 0;
        cfd = $fopen(golden_path, "r");
        if (cfd == 0) begin
            return 0;
        end
        while ($fscanf(cfd, " %c", cmd) == 1) begin
            if (cmd != "#") begin
                n++;
            end
            void'($fgets(rest, cfd));
        end
        $fclose(cfd);
        return n;
    endfunction

    task automatic run_commands();
        logic [7:0]    cmd;
        logic [1023:0] rest;
        int            got;
        int            num;
        num = 0;
        got = $fscanf(fd, " %c", cmd);
        while (got == 1 && file_errors == 0) begin
            if (cmd == "#") begin
                void'($fgets(rest, fd));
            end else begin
                num++;
                case (cmd)
                    "W": begin
                        got = $fscanf(fd, "%d %h %h %d %h %h %h %h %h %h %h %h %h %h %h %h",
                                      w_index, w_e, w_vppn, w_ps, w_asid, w_g, w_ppn0, w_plv0,
                                      w_mat0, w_d0, w_v0, w_ppn1, w_plv1, w_mat1, w_d1, w_v1);
                        if (got == 16) begin
                            we = 1'b1;
                            @(negedge clk);
                            we = 1'b0;
                        end else begin
                            report_bad_line(num, cmd);
                        end
                    end
                    "I": begin
                        got = $fscanf(fd, "%d %h %h", op_code, s_asid, s_vppn);
                        if (got == 3) begin
                            invtlb_op = invtlb_op_e'(op_code);     // may be reserved
                            invtlb_valid = 1'b1;
                            @(negedge clk);
                            invtlb_valid = 1'b0;
                        end else begin
                            report_bad_line(num, cmd);
                        end
                    end
                    "S": begin
                        got = $fscanf(fd, "%h %h %h %h %d %h %d %h %h %h %h", s_vppn, s_va_bit12,
                                      s_asid, exp_found, exp_index, exp_ppn[0], exp_ps,
                                      exp_plv[0], exp_mat[0], exp_d[0], exp_v[0]);
                        if (got == 11) begin
                            @(negedge clk);
                            check_search(exp_found, exp_index, exp_ppn[0], exp_ps, exp_plv[0],
                                         exp_mat[0], exp_d[0], exp_v[0]);
                        end else begin
                            report_bad_line(num, cmd);
                        end
                    end
                    "R": begin
                        got = $fscanf(fd, "%d %h %h %h %d %h %h %h %h %h %h %h %h %h %h %h %h",
                                      r_index, full_check, exp_e, exp_vppn, exp_ps, exp_asid,
                                      exp_g, exp_ppn[0], exp_plv[0], exp_mat[0], exp_d[0],
                                      exp_v[0], exp_ppn[1], exp_plv[1], exp_mat[1], exp_d[1],
                                      exp_v[1]);
                        if (got == 17) begin
                            @(negedge clk);
                            check_read(full_check, exp_e, exp_vppn, exp_ps, exp_asid, exp_g,
                                       exp_ppn[0], exp_plv[0], exp_mat[0], exp_d[0], exp_v[0],
                                       exp_ppn[1], exp_plv[1], exp_mat[1], exp_d[1], exp_v[1]);
                        end else begin
                            report_bad_line(num, cmd);
                        end
                    end
                    default: begin
                        file_errors++;
                        $display("golden file command %0d has an unknown letter %c", num, cmd);
                    end
                endcase
            end
            got = $fscanf(fd, " %c", cmd);
        end
    endtask

    initial begin
        s_vppn = '0;
        s_va_bit12 = 1'b0;
        s_asid = '0;
        invtlb_valid = 1'b0;
        invtlb_op = inv_all0;
        we = 1'b0;
        w_index = '0;
        w_e = 1'b0;
        w_vppn = '0;
        w_ps = '0;
        w_asid = '0;
        w_g = 1'b0;
        w_ppn0 = '0;
        w_ppn1 = '0;
        w_plv0 = '0;
        w_plv1 = '0;
        w_mat0 = '0;
        w_mat1 = '0;
        w_d0 = 1'b0;
        w_d1 = 1'b0;
        w_v0 = 1'b0;
        w_v1 = 1'b0;
        r_index = '0;

        n_cmds = count_commands();
        if (n_cmds == 0) begin
            file_errors++;
            $display("golden file %s is missing or holds no commands", golden_path);
        end else begin
            cycle_limit = 4 * n_cmds + 20;
            wait (reset === 1'b0);
            @(negedge clk);                     // inputs change on falling edges
            fd = $fopen(golden_path, "r");
            run_commands();
            $fclose(fd);
        end

        $display("checks %0d, mismatches %0d, golden file errors %0d",
                 checks, mismatches, file_errors);
        if (mismatches == 0 && file_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- dv/tlb_golden.txt
# W idx e vppn ps asid g ppn0 plv0 mat0 d0 v0 ppn1 plv1 mat1 d1 v1
# I op asid vppn / S vppn va_bit12 asid found idx ppn ps plv mat d v
# R idx full e vppn ps asid g ppn0 plv0 mat0 d0 v0 ppn1 plv1 mat1 d1 v1
# idx, ps and op are decimal, all else hex; an R with full 0 checks only e
S 12345 0 055 0 0 00000 0 0 0 0 0
S 7ffff 1 3ff 0 0 00000 0 0 0 0 0
R 0 0 0 00000 0 000 0 00000 0 0 0 0 00000 0 0 0 0
R 15 0 0 00000 0 000 0 00000 0 0 0 0 00000 0 0 0 0
# 4 KB page pair
W 3 1 12345 12 055 0 a1b2c 1 2 1 0 d3e4f 2 1 0 1
S 12345 0 055 1 3 a1b2c 12 1 2 1 0
S 12345 1 055 1 3 d3e4f 12 2 1 0 1
S 12344 0 055 0 0 00000 0 0 0 0 0
S 12745 1 055 0 0 00000 0 0 0 0 0
S 52345 0 055 0 0 00000 0 0 0 0 0
# 4 MB page pair
W 7 1 2a9ff 22 055 0 11111 0 1 1 1 22222 3 0 0 1
S 2a800 1 055 1 7 11111 22 0 1 1 1
S 2aa00 0 055 1 7 22222 22 3 0 0 1
S 2ac00 0 055 0 0 00000 0 0 0 0 0
R 7 1 1 2a9ff 22 055 0 11111 0 1 1 1 22222 3 0 0 1
# ASID, global and priority
S 12345 0 056 0 0 00000 0 0 0 0 0
W 9 1 30000 12 1aa 1 33333 1 1 1 1 44444 2 3 0 0
S 30000 1 2ff 1 9 44444 12 2 3 0 0
W 1 1 30000 12 077 0 77777 2 2 0 1 88888 2 2 1 0
S 30000 0 077 1 1 77777 12 2 2 0 1
S 30000 0 000 1 9 33333 12 1 1 1 1
W 12 1 12345 12 055 0 55555 0 0 0 0 66666 0 0 0 0
S 12345 1 055 1 3 d3e4f 12 2 1 0 1
R 9 1 1 30000 12 1aa 1 33333 1 1 1 1 44444 2 3 0 0
# INVTLB
I 9 055 12345
S 12345 0 055 1 3 a1b2c 12 1 2 1 0
I 5 055 12345
S 12345 0 055 0 0 00000 0 0 0 0 0
R 7 0 1 00000 0 000 0 00000 0 0 0 0 00000 0 0 0 0
R 12 0 0 00000 0 000 0 00000 0 0 0 0 00000 0 0 0 0
I 6 000 30000
S 30000 0 000 0 0 00000 0 0 0 0 0
R 1 0 1 00000 0 000 0 00000 0 0 0 0 00000 0 0 0 0
I 4 077 00000
R 1 0 0 00000 0 000 0 00000 0 0 0 0 00000 0 0 0 0
R 7 0 1 00000 0 000 0 00000 0 0 0 0 00000 0 0 0 0
W 9 1 30000 12 1aa 1 33333 1 1 1 1 44444 2 3 0 0
W 3 1 12345 12 055 0 a1b2c 1 2 1 0 d3e4f 2 1 0 1
I 3 000 00000
R 3 0 0 00000 0 000 0 00000 0 0 0 0 00000 0 0 0 0
R 7 0 0 00000 0 000 0 00000 0 0 0 0 00000 0 0 0 0
S 30000 1 2ff 1 9 44444 12 2 3 0 0
W 3 1 12345 12 055 0 a1b2c 1 2 1 0 d3e4f 2 1 0 1
I 2 000 00000
R 9 0 0 00000 0 000 0 00000 0 0 0 0 00000 0 0 0 0
S 12345 1 055 1 3 d3e4f 12 2 1 0 1
W 9 1 30000 12 1aa 1 33333 1 1 1 1 44444 2 3 0 0
I 0 000 00000
R 3 0 0 00000 0 000 0 00000 0 0 0 0 00000 0 0 0 0
R 9 0 0 00000 0 000 0 00000 0 0 0 0 00000 0 0 0 0
W 3 1 12345 12 055 0 a1b2c 1 2 1 0 d3e4f 2 1 0 1
I 1 000 00000
S 12345 0 055 0 0 00000 0 0 0 0 0
# write port corner cases
W 5 0 40000 12 123 1 abcde 3 3 1 1 fedcb 3 3 1 1
S 40000 0 123 0 0 00000 0 0 0 0 0
R 5 1 0 40000 12 123 1 abcde 3 3 1 1 fedcb 3 3 1 1
W 10 1 50000 22 001 0 12121 1 0 1 0 34343 0 1 0 1
W 10 1 50000 16 001 0 56565 1 0 1 0 78787 0 1 0 1
R 10 1 1 50000 22 001 0 56565 1 0 1 0 78787 0 1 0 1
S 503ff 1 001 1 10 78787 22 0 1 0 1

//--- flist.f
hw/tlb_pkg.sv
hw/tlb_entry_array.sv
hw/tlb_match.sv
hw/tlb_invtlb_decode.sv
hw/tlb_lookup.sv
hw/tlb_top.sv
dv/tb_clock_gen.sv
dv/tb_tlb.sv

//--- hw/tlb_entry_array.sv
module tlb_entry_array (
    input  logic                                     clk,
    input  logic                                     reset,
    // write port
    input  logic                                     we,
    input  tlb_pkg::index_t                          w_index,
    input  logic                                     w_e,
    input  tlb_pkg::vppn_t                           w_vppn,
    input  tlb_pkg::ps_t                             w_ps,
    input  tlb_pkg::asid_t                           w_asid,
    input  logic                                     w_g,
    input  tlb_pkg::ppn_t                            w_ppn0,
    input  tlb_pkg::ppn_t                            w_ppn1,
    input  tlb_pkg::plv_t                            w_plv0,
    input  tlb_pkg::plv_t                            w_plv1,
    input  tlb_pkg::mat_t                            w_mat0,
    input  tlb_pkg::mat_t                            w_mat1,
    input  logic                                     w_d0,
    input  logic                                     w_d1,
    input  logic                                     w_v0,
    input  logic                                     w_v1,
    // invalidate
    input  logic                                     inv_valid,
    input  tlb_pkg::entry_vec_t                      inv_mask,
    // read port
    input  tlb_pkg::index_t                          r_index,
    output logic                                     r_e,
    output tlb_pkg::vppn_t                           r_vppn,
    output tlb_pkg::ps_t                             r_ps,
    output tlb_pkg::asid_t                           r_asid,
    output logic                                     r_g,
    output tlb_pkg::ppn_t                            r_ppn0,
    output tlb_pkg::ppn_t                            r_ppn1,
    output tlb_pkg::plv_t                            r_plv0,
    output tlb_pkg::plv_t                            r_plv1,
    output tlb_pkg::mat_t                            r_mat0,
    output tlb_pkg::mat_t                            r_mat1,
    output logic                                     r_d0,
    output logic                                     r_d1,
    output logic                                     r_v0,
    output logic                                     r_v1,
    // entry contents for search and invalidate
    output tlb_pkg::entry_vec_t                      ent_e,
    output tlb_pkg::entry_vec_t                      ent_g,
    output tlb_pkg::entry_vec_t                      ent_ps4mb,
    output tlb_pkg::vppn_t [tlb_pkg::tlb_num-1:0]    ent_vppn,
    output tlb_pkg::asid_t [tlb_pkg::tlb_num-1:0]    ent_asid,
    output tlb_pkg::ppn_t  [tlb_pkg::tlb_num-1:0]    ent_ppn0,
    output tlb_pkg::ppn_t  [tlb_pkg::tlb_num-1:0]    ent_ppn1,
    output tlb_pkg::plv_t  [tlb_pkg::tlb_num-1:0]    ent_plv0,
    output tlb_pkg::plv_t  [tlb_pkg::tlb_num-1:0]    ent_plv1,
    output tlb_pkg::mat_t  [tlb_pkg::tlb_num-1:0]    ent_mat0,
    output tlb_pkg::mat_t  [tlb_pkg::tlb_num-1:0]    ent_mat1,
    output tlb_pkg::entry_vec_t                      ent_d0,
    output tlb_pkg::entry_vec_t                      ent_d1,
    output tlb_pkg::entry_vec_t                      ent_v0,
    output tlb_pkg::entry_vec_t                      ent_v1
);
    import tlb_pkg::*;

    entry_vec_t e_next;

    // invalidate first, then the write lands on top
    always_comb begin
        e_next = ent_e;
        if (inv_valid) begin
            e_next = e_next & ~inv_mask;
        end
        if (we) begin
            e_next[w_index] = w_e;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ent_e <= '0;                        // all entries empty
        end else begin
            ent_e <= e_next;
        end
    end

    // payload fields
    always_ff @(posedge clk) begin
        if (we) begin
            ent_vppn[w_index] <= w_vppn;
            ent_asid[w_index] <= w_asid;
            ent_g[w_index]    <= w_g;
            ent_ppn0[w_index] <= w_ppn0;
            ent_ppn1[w_index] <= w_ppn1;
            ent_plv0[w_index] <= w_plv0;
            ent_plv1[w_index] <= w_plv1;
            ent_mat0[w_index] <= w_mat0;
            ent_mat1[w_index] <= w_mat1;
            ent_d0[w_index]   <= w_d0;
            ent_d1[w_index]   <= w_d1;
            ent_v0[w_index]   <= w_v0;
            ent_v1[w_index]   <= w_v1;
            if (w_ps == ps_4mb) begin
                ent_ps4mb[w_index] <= 1'b1;
            end else if (w_ps == ps_4kb) begin
                ent_ps4mb[w_index] <= 1'b0;     // other codes keep the old size
            end
        end
    end

    assign r_e    = ent_e[r_index];
    assign r_vppn = ent_vppn[r_index];
    assign r_ps   = ent_ps4mb[r_index] ? ps_4mb : ps_4kb;
    assign r_asid = ent_asid[r_index];
    assign r_g    = ent_g[r_index];
    assign r_ppn0 = ent_ppn0[r_index];
    assign r_ppn1 = ent_ppn1[r_index];
    assign r_plv0 = ent_plv0[r_index];
    assign r_plv1 = ent_plv1[r_index];
    assign r_mat0 = ent_mat0[r_index];
    assign r_mat1 = ent_mat1[r_index];
    assign r_d0   = ent_d0[r_index];
    assign r_d1   = ent_d1[r_index];
    assign r_v0   = ent_v0[r_index];
    assign r_v1   = ent_v1[r_index];

endmodule

//--- hw/tlb_invtlb_decode.sv
module tlb_invtlb_decode (
    input  tlb_pkg::invtlb_op_e   invtlb_op,
    input  tlb_pkg::entry_vec_t   ent_g,
    input  tlb_pkg::entry_vec_t   asid_hit,
    input  tlb_pkg::entry_vec_t   va_hit,
    output tlb_pkg::entry_vec_t   inv_mask
);
    import tlb_pkg::*;

    entry_vec_t nonglob;

    assign nonglob = ~ent_g;

    // ASID and VA operands come from the search inputs upstream
    always_comb begin
        case (invtlb_op)
            inv_all0,
            inv_all1: begin
                inv_mask = '1;
            end
            inv_glob: begin
                inv_mask = ent_g;
            end
            inv_nonglob: begin
                inv_mask = nonglob;
            end
            inv_asid: begin
                inv_mask = nonglob & asid_hit;
            end
            inv_asid_va: begin
                inv_mask = nonglob & asid_hit & va_hit;
            end
            inv_va: begin
                inv_mask = (ent_g | asid_hit) & va_hit;
            end
            default: begin
                inv_mask = '0;                  // reserved op has no effect
            end
        endcase
    end

endmodule

//--- hw/tlb_lookup.sv
module tlb_lookup (
    input  tlb_pkg::vppn_t                           s_vppn,
    input  logic                                     s_va_bit12,
    input  tlb_pkg::entry_vec_t                      ent_e,
    input  tlb_pkg::entry_vec_t                      ent_g,
    input  tlb_pkg::entry_vec_t                      ent_ps4mb,
    input  tlb_pkg::entry_vec_t                      va_hit,
    input  tlb_pkg::entry_vec_t                      asid_hit,
    input  tlb_pkg::ppn_t  [tlb_pkg::tlb_num-1:0]    ent_ppn0,
    input  tlb_pkg::ppn_t  [tlb_pkg::tlb_num-1:0]    ent_ppn1,
    input  tlb_pkg::plv_t  [tlb_pkg::tlb_num-1:0]    ent_plv0,
    input  tlb_pkg::plv_t  [tlb_pkg::tlb_num-1:0]    ent_plv1,
    input  tlb_pkg::mat_t  [tlb_pkg::tlb_num-1:0]    ent_mat0,
    input  tlb_pkg::mat_t  [tlb_pkg::tlb_num-1:0]    ent_mat1,
    input  tlb_pkg::entry_vec_t                      ent_d0,
    input  tlb_pkg::entry_vec_t                      ent_d1,
    input  tlb_pkg::entry_vec_t                      ent_v0,
    input  tlb_pkg::entry_vec_t                      ent_v1,
    output logic                                     s_found,
    output tlb_pkg::index_t                          s_index,
    output tlb_pkg::ppn_t                            s_ppn,
    output tlb_pkg::ps_t                             s_ps,
    output tlb_pkg::plv_t                            s_plv,
    output tlb_pkg::mat_t                            s_mat,
    output logic                                     s_d,
    output logic                                     s_v
);
    import tlb_pkg::*;

    entry_vec_t hit;
    logic       odd_sel;

    assign hit = ent_e & va_hit & (ent_g | asid_hit);

    // scan downward so the lowest index wins
    always_comb begin
        s_found = 1'b0;
        s_index = '0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (hit[i]) begin
                s_found = 1'b1;
                s_index = index_t'(i);
            end
        end
    end

    assign odd_sel = ent_ps4mb[s_index] ? s_vppn[vppn_split-1] : s_va_bit12;

    always_comb begin
        s_ppn = '0;                             // miss returns all zero
        s_ps  = '0;
        s_plv = '0;
        s_mat = '0;
        s_d   = 1'b0;
        s_v   = 1'b0;
        if (s_found) begin
            s_ps = ent_ps4mb[s_index] ? ps_4mb : ps_4kb;
            if (odd_sel) begin
                s_ppn = ent_ppn1[s_index];
                s_plv = ent_plv1[s_index];
                s_mat = ent_mat1[s_index];
                s_d   = ent_d1[s_index];
                s_v   = ent_v1[s_index];
            end else begin
                s_ppn = ent_ppn0[s_index];
                s_plv = ent_plv0[s_index];
                s_mat = ent_mat0[s_index];
                s_d   = ent_d0[s_index];
                s_v   = ent_v0[s_index];
            end
        end
    end

endmodule

//--- hw/tlb_match.sv
module tlb_match (
    input  tlb_pkg::vppn_t                           s_vppn,
    input  tlb_pkg::asid_t                           s_asid,
    input  tlb_pkg::vppn_t [tlb_pkg::tlb_num-1:0]    ent_vppn,
    input  tlb_pkg::asid_t [tlb_pkg::tlb_num-1:0]    ent_asid,
    input  tlb_pkg::entry_vec_t                      ent_ps4mb,
    output tlb_pkg::entry_vec_t                      va_hit,
    output tlb_pkg::entry_vec_t                      asid_hit
);
    import tlb_pkg::*;

    localparam int vppn_msb = $bits(vppn_t) - 1;

    logic [tlb_num-1:0] hi_eq;
    logic [tlb_num-1:0] lo_eq;

    // one comparator set per entry
    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            hi_eq[i] = s_vppn[vppn_msb:vppn_split] == ent_vppn[i][vppn_msb:vppn_split];
            lo_eq[i] = s_vppn[vppn_split-1:0] == ent_vppn[i][vppn_split-1:0];
            asid_hit[i] = s_asid == ent_asid[i];
        end
    end

    // 4 MB pages don't care about the low part
    assign va_hit = hi_eq & (ent_ps4mb | lo_eq);

endmodule

//--- hw/tlb_pkg.sv
package tlb_pkg;

    // TLB geometry
    localparam int tlb_num = 16;
    localparam int index_w = $clog2(tlb_num);

    typedef logic [index_w-1:0] index_t;
    typedef logic [tlb_num-1:0] entry_vec_t;   // one bit per entry

    // entry field types
    typedef logic [18:0] vppn_t;                // va[31:13]
    typedef logic [9:0]  asid_t;
    typedef logic [19:0] ppn_t;
    typedef logic [5:0]  ps_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;

    // a 4 MB entry ignores vppn[9:0]; bit 9 picks the odd page
    localparam int vppn_split = 10;

    // page size codes as seen on the ports
    localparam ps_t ps_4kb = 6'd12;
    localparam ps_t ps_4mb = 6'd22;

    // INVTLB operation codes
    typedef enum logic [4:0] {
        inv_all0    = 5'd0,                     // clear everything
        inv_all1    = 5'd1,                     // same as 0
        inv_glob    = 5'd2,                     // g = 1 only
        inv_nonglob = 5'd3,                     // g = 0 only
        inv_asid    = 5'd4,                     // g = 0, asid match
        inv_asid_va = 5'd5,                     // g = 0, asid and va match
        inv_va      = 5'd6                      // (g = 1 or asid match), va match
    } invtlb_op_e;

endpackage

//--- hw/tlb_top.sv
module tlb_top (
    input  logic                   clk,
    input  logic                   reset,
    // search port and INVTLB operands
    input  tlb_pkg::vppn_t         s_vppn,
    input  logic                   s_va_bit12,
    input  tlb_pkg::asid_t         s_asid,
    output logic                   s_found,
    output tlb_pkg::index_t        s_index,
    output tlb_pkg::ppn_t          s_ppn,
    output tlb_pkg::ps_t           s_ps,
    output tlb_pkg::plv_t          s_plv,
    output tlb_pkg::mat_t          s_mat,
    output logic                   s_d,
    output logic                   s_v,
    // INVTLB
    input  logic                   invtlb_valid,
    input  tlb_pkg::invtlb_op_e    invtlb_op,
    // write port
    input  logic                   we,
    input  tlb_pkg::index_t        w_index,
    input  logic                   w_e,
    input  tlb_pkg::vppn_t         w_vppn,
    input  tlb_pkg::ps_t           w_ps,
    input  tlb_pkg::asid_t         w_asid,
    input  logic                   w_g,
    input  tlb_pkg::ppn_t          w_ppn0,
    input  tlb_pkg::plv_t          w_plv0,
    input  tlb_pkg::mat_t          w_mat0,
    input  logic                   w_d0,
    input  logic                   w_v0,
    input  tlb_pkg::ppn_t          w_ppn1,
    input  tlb_pkg::plv_t          w_plv1,
    input  tlb_pkg::mat_t          w_mat1,
    input  logic                   w_d1,
    input  logic                   w_v1,
    // read port
    input  tlb_pkg::index_t        r_index,
    output logic                   r_e,
    output tlb_pkg::vppn_t         r_vppn,
    output tlb_pkg::ps_t           r_ps,
    output tlb_pkg::asid_t         r_asid,
    output logic                   r_g,
    output tlb_pkg::ppn_t          r_ppn0,
    output tlb_pkg::plv_t          r_plv0,
    output tlb_pkg::mat_t          r_mat0,
    output logic                   r_d0,
    output logic                   r_v0,
    output tlb_pkg::ppn_t          r_ppn1,
    output tlb_pkg::plv_t          r_plv1,
    output tlb_pkg::mat_t          r_mat1,
    output logic                   r_d1,
    output logic                   r_v1
);
    import tlb_pkg::*;

    entry_vec_t             ent_e;
    entry_vec_t             ent_g;
    entry_vec_t             ent_ps4mb;
    vppn_t [tlb_num-1:0]    ent_vppn;
    asid_t [tlb_num-1:0]    ent_asid;
    ppn_t  [tlb_num-1:0]    ent_ppn0;
    ppn_t  [tlb_num-1:0]    ent_ppn1;
    plv_t  [tlb_num-1:0]    ent_plv0;
    plv_t  [tlb_num-1:0]    ent_plv1;
    mat_t  [tlb_num-1:0]    ent_mat0;
    mat_t  [tlb_num-1:0]    ent_mat1;
    entry_vec_t             ent_d0;
    entry_vec_t             ent_d1;
    entry_vec_t             ent_v0;
    entry_vec_t             ent_v1;
    entry_vec_t             va_hit;
    entry_vec_t             asid_hit;
    entry_vec_t             inv_mask;

    tlb_entry_array u_entry_array (
        .clk       (clk),
        .reset     (reset),
        .we        (we),
        .w_index   (w_index),
        .w_e       (w_e),
        .w_vppn    (w_vppn),
        .w_ps      (w_ps),
        .w_asid    (w_asid),
        .w_g       (w_g),
        .w_ppn0    (w_ppn0),
        .w_ppn1    (w_ppn1),
        .w_plv0    (w_plv0),
        .w_plv1    (w_plv1),
        .w_mat0    (w_mat0),
        .w_mat1    (w_mat1),
        .w_d0      (w_d0),
        .w_d1      (w_d1),
        .w_v0      (w_v0),
        .w_v1      (w_v1),
        .inv_valid (invtlb_valid),
        .inv_mask  (inv_mask),
        .r_index   (r_index),
        .r_e       (r_e),
        .r_vppn    (r_vppn),
        .r_ps      (r_ps),
        .r_asid    (r_asid),
        .r_g       (r_g),
        .r_ppn0    (r_ppn0),
        .r_ppn1    (r_ppn1),
        .r_plv0    (r_plv0),
        .r_plv1    (r_plv1),
        .r_mat0    (r_mat0),
        .r_mat1    (r_mat1),
        .r_d0      (r_d0),
        .r_d1      (r_d1),
        .r_v0      (r_v0),
        .r_v1      (r_v1),
        .ent_e     (ent_e),
        .ent_g     (ent_g),
        .ent_ps4mb (ent_ps4mb),
        .ent_vppn  (ent_vppn),
        .ent_asid  (ent_asid),
        .ent_ppn0  (ent_ppn0),
        .ent_ppn1  (ent_ppn1),
        .ent_plv0  (ent_plv0),
        .ent_plv1  (ent_plv1),
        .ent_mat0  (ent_mat0),
        .ent_mat1  (ent_mat1),
        .ent_d0    (ent_d0),
        .ent_d1    (ent_d1),
        .ent_v0    (ent_v0),
        .ent_v1    (ent_v1)
    );

    // shared by search and INVTLB
    tlb_match u_match (
        .s_vppn    (s_vppn),
        .s_asid    (s_asid),
        .ent_vppn  (ent_vppn),
        .ent_asid  (ent_asid),
        .ent_ps4mb (ent_ps4mb),
        .va_hit    (va_hit),
        .asid_hit  (asid_hit)
    );

    tlb_invtlb_decode u_invtlb_decode (
        .invtlb_op (invtlb_op),
        .ent_g     (ent_g),
        .asid_hit  (asid_hit),
        .va_hit    (va_hit),
        .inv_mask  (inv_mask)
    );

    tlb_lookup u_lookup (
        .s_vppn     (s_vppn),
        .s_va_bit12 (s_va_bit12),
        .ent_e      (ent_e),
        .ent_g      (ent_g),
        .ent_ps4mb  (ent_ps4mb),
        .va_hit     (va_hit),
        .asid_hit   (asid_hit),
        .ent_ppn0   (ent_ppn0),
        .ent_ppn1   (ent_ppn1),
        .ent_plv0   (ent_plv0),
        .ent_plv1   (ent_plv1),
        .ent_mat0   (ent_mat0),
        .ent_mat1   (ent_mat1),
        .ent_d0     (ent_d0),
        .ent_d1     (ent_d1),
        .ent_v0     (ent_v0),
        .ent_v1     (ent_v1),
        .s_found    (s_found),
        .s_index    (s_index),
        .s_ppn      (s_ppn),
        .s_ps       (s_ps),
        .s_plv      (s_plv),
        .s_mat      (s_mat),
        .s_d        (s_d),
        .s_v        (s_v)
    );

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps --top-module tb_tlb -f flist.f -o tb_tlb

output=$(./obj_dir/tb_tlb)
echo "$output"

if echo "$output" | grep -q "TESTS PASSED"; then
    exit 0
else
    exit 1
fi
